// ==== Makefile ====
# Verilator build and run for the pipeline testbench

VERILATOR ?= verilator
TOP       ?= pipeline_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= All tests passed

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/dp_is_stage.sv ====
////////////////////
// dispatch and issue
// decode, register file, scoreboard,
// raw/waw stall and halt latch
////////////////////

module dp_is_stage
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  if_packet_t  if_id_packet,
	input  cdb_packet_t cdb_packet,
	output is_packet_t  is_packet,
	output logic        stall,
	output logic        halt_fetch
);

	inst_t           inst;
	logic [4:0]      rs1_idx;
	logic [4:0]      rs2_idx;
	logic [4:0]      rd_idx;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [xlen-1:0] i_imm;
	logic [xlen-1:0] u_imm;

	// decode outputs
	logic            uses_rs1;
	logic            uses_rs2;
	logic            writes_rd;
	logic            is_halt;
	logic            is_illegal;
	alu_func_t       alu_func;
	opb_select_t     opb_select;

	// x1..x31, x0 is hardwired
	logic [xlen-1:0] regs [31:1];
	// one busy bit per register, bit 0 never set
	logic [31:0]     scoreboard;
	logic            hazard;
	logic            issue;
	logic            cdb_write;

	// instruction fields
	assign inst    = if_id_packet.inst;
	assign rd_idx  = inst[11:7];
	assign funct3  = inst[14:12];
	assign rs1_idx = inst[19:15];
	assign rs2_idx = inst[24:20];
	assign funct7  = inst[31:25];
	assign i_imm   = {{20{inst[31]}}, inst[31:20]};
	assign u_imm   = {inst[31:12], 12'b0};

	////////////////////
	// decode
	////////////////////
	always_comb begin
		uses_rs1   = 1'b0;
		uses_rs2   = 1'b0;
		writes_rd  = 1'b0;
		is_halt    = 1'b0;
		is_illegal = 1'b0;
		alu_func   = alu_add;
		opb_select = opb_is_rs2;
		case (inst[6:0])
			opc_op: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: alu_func = alu_add;
					{7'b0100000, 3'b000}: alu_func = alu_sub;
					{7'b0000000, 3'b111}: alu_func = alu_and;
					{7'b0000000, 3'b110}: alu_func = alu_or;
					{7'b0000000, 3'b100}: alu_func = alu_xor;
					{7'b0000000, 3'b010}: alu_func = alu_slt;
					default:              is_illegal = 1'b1;
				endcase
			end
			opc_op_imm: begin
				uses_rs1   = 1'b1;
				opb_select = opb_is_i_imm;
				case (funct3)
					3'b000:  alu_func = alu_add;
					3'b111:  alu_func = alu_and;
					3'b110:  alu_func = alu_or;
					3'b100:  alu_func = alu_xor;
					default: is_illegal = 1'b1;
				endcase
			end
			// rd = 0 + upper immediate
			opc_lui:    opb_select = opb_is_u_imm;
			// only wfi is supported here
			opc_system: begin
				is_halt    = (inst == wfi_inst);
				is_illegal = (inst != wfi_inst);
			end
			default:    is_illegal = 1'b1;
		endcase
		// writes to x0 are dropped
		writes_rd = !is_illegal && !is_halt && (rd_idx != 5'd0);
	end

	////////////////////
	// hazard and issue
	////////////////////
	// raw on either source, waw on the destination
	assign hazard = (uses_rs1 && scoreboard[rs1_idx])
		|| (uses_rs2 && scoreboard[rs2_idx])
		|| (writes_rd && scoreboard[rd_idx]);
	assign stall  = if_id_packet.valid && !halt_fetch && hazard;
	assign issue  = if_id_packet.valid && !halt_fetch && !hazard;

	assign cdb_write = cdb_packet.valid && cdb_packet.wr_en;

	// register file, written by the broadcast
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (cdb_write && (cdb_packet.dest_idx != 5'd0)) begin
			regs[cdb_packet.dest_idx] <= cdb_packet.result;
		end
	end

	// busy bits, set at issue and cleared by the broadcast
	always_ff @(posedge clock) begin
		if (reset) begin
			scoreboard <= '0;
		end else begin
			if (cdb_write) begin
				scoreboard[cdb_packet.dest_idx] <= 1'b0;
			end
			if (issue && writes_rd) begin
				scoreboard[rd_idx] <= 1'b1;
			end
		end
	end

	// sticky until reset
	always_ff @(posedge clock) begin
		if (reset) begin
			halt_fetch <= 1'b0;
		end else if (issue && (is_halt || is_illegal)) begin
			halt_fetch <= 1'b1;
		end
	end

	// issue packet
	always_comb begin
		is_packet.valid      = issue;
		is_packet.pc         = if_id_packet.pc;
		is_packet.npc        = if_id_packet.npc;
		is_packet.rs1_value  = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
		is_packet.rs2_value  = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];
		is_packet.imm        = (opb_select == opb_is_u_imm) ? u_imm : i_imm;
		is_packet.opb_select = opb_select;
		is_packet.alu_func   = alu_func;
		is_packet.dest_idx   = writes_rd ? rd_idx : 5'd0;
		is_packet.wr_en      = writes_rd;
		is_packet.halt       = is_halt;
		is_packet.illegal    = is_illegal;
	end

endmodule

// ==== design/ex_stage.sv ====
////////////////////
// execute stage
// operand select and alu, forms the broadcast packet
////////////////////

module ex_stage
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  is_packet_t  is_ex_packet,
	output cdb_packet_t cdb_result
);

	logic [xlen-1:0] opa;
	logic [xlen-1:0] opb;
	logic [xlen-1:0] result;

	// lui takes a zero operand a
	assign opa = (is_ex_packet.opb_select == opb_is_u_imm) ? '0 : is_ex_packet.rs1_value;

	// operand b mux
	always_comb begin
		case (is_ex_packet.opb_select)
			opb_is_i_imm: opb = is_ex_packet.imm;
			opb_is_u_imm: opb = is_ex_packet.imm;
			default:      opb = is_ex_packet.rs2_value;
		endcase
	end

	// alu
	always_comb begin
		case (is_ex_packet.alu_func)
			alu_sub: result = opa - opb;
			alu_and: result = opa & opb;
			alu_or:  result = opa | opb;
			alu_xor: result = opa ^ opb;
			// signed compare, zero extended to xlen
			alu_slt: result = {{(xlen - 1){1'b0}}, $signed(opa) < $signed(opb)};
			default: result = opa + opb;
		endcase
	end

	// broadcast packet
	always_comb begin
		cdb_result.valid    = is_ex_packet.valid;
		cdb_result.npc      = is_ex_packet.npc;
		cdb_result.dest_idx = is_ex_packet.dest_idx;
		cdb_result.wr_en    = is_ex_packet.wr_en;
		cdb_result.result   = result;
		cdb_result.halt     = is_ex_packet.halt;
		cdb_result.illegal  = is_ex_packet.illegal;
	end

endmodule

// ==== design/if_stage.sv ====
////////////////////
// fetch stage
// holds the pc, drives the fetch address and
// packs the returned word into the fetch packet
////////////////////

module if_stage
	import isa_pkg::*;
	import pipe_pkg::*;
#(
	parameter logic [xlen-1:0] reset_pc = '0
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            stall,
	input  logic            halt_fetch,
	input  inst_t           mem2proc_data,
	output logic [xlen-1:0] proc2mem_addr,
	output if_packet_t      if_packet
);

	logic [xlen-1:0] pc;
	logic [xlen-1:0] npc;

	// sequential fetch only
	assign npc = pc + 32'd4;

	// memory answers in the same cycle
	assign proc2mem_addr = pc;

	// pc register
	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= reset_pc;
		end else if (!stall && !halt_fetch) begin
			pc <= npc;
		end
	end

	// fetch packet
	// once halted, nop with valid low
	always_comb begin
		if_packet.valid = !halt_fetch;
		if_packet.pc    = pc;
		if_packet.npc   = npc;
		if_packet.inst  = halt_fetch ? nop_inst : mem2proc_data;
	end

endmodule

// ==== design/isa_pkg.sv ====
////////////////////
// isa definitions
// data width, instruction encodings, alu and operand selects,
// and the error codes reported at retire
////////////////////

package isa_pkg;

	// data path width
	localparam int xlen = 32;

	// raw instruction word
	typedef logic [31:0] inst_t;

	// addi x0, x0, 0
	localparam inst_t nop_inst = 32'h0000_0013;
	// wait for interrupt, used as halt
	localparam inst_t wfi_inst = 32'h1050_0073;

	// major opcodes that are decoded
	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_lui    = 7'b0110111,
		opc_system = 7'b1110011
	} opcode_t;

	// alu operations
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_func_t;

	// source of alu operand b
	typedef enum logic [1:0] {
		opb_is_rs2,
		opb_is_i_imm,
		opb_is_u_imm
	} opb_select_t;

	// status shown on the commit port
	typedef enum logic [1:0] {
		no_error,
		halted_on_wfi,
		illegal_inst
	} error_code_t;

endpackage

// ==== design/pipe_pkg.sv ====
////////////////////
// pipeline packets
// structs passed between stages and the result broadcast
////////////////////

package pipe_pkg;

	import isa_pkg::*;

	// fetch to dispatch, 97 bits
	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] npc;
		inst_t           inst;
	} if_packet_t;

	// dispatch/issue to execute
	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] npc;
		logic [xlen-1:0] rs1_value;
		logic [xlen-1:0] rs2_value;
		// i or u immediate, already expanded
		logic [xlen-1:0] imm;
		opb_select_t     opb_select;
		alu_func_t       alu_func;
		logic [4:0]      dest_idx;
		logic            wr_en;
		// wfi seen
		logic            halt;
		logic            illegal;
	} is_packet_t;

	// result broadcast, feeds the register file and retire
	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] npc;
		logic [4:0]      dest_idx;
		logic            wr_en;
		logic [xlen-1:0] result;
		logic            halt;
		logic            illegal;
	} cdb_packet_t;

endpackage

// ==== design/pipeline.sv ====
////////////////////
// pipeline top level
// fetch, dispatch/issue, execute, broadcast and retire,
// joined by three pipeline registers
////////////////////

module pipeline
	import isa_pkg::*;
	import pipe_pkg::*;
#(
	parameter logic [xlen-1:0] reset_pc = '0
) (
	input  logic            clock,
	input  logic            reset,
	input  inst_t           mem2proc_data,
	output logic [xlen-1:0] proc2mem_addr,
	output logic            commit_valid,
	output logic [xlen-1:0] commit_npc,
	output logic            commit_wr_en,
	output logic [4:0]      commit_wr_idx,
	output logic [xlen-1:0] commit_wr_data,
	output error_code_t     error_status
);

	if_packet_t  if_packet;
	if_packet_t  if_id_packet;
	is_packet_t  is_packet;
	is_packet_t  is_ex_packet;
	cdb_packet_t ex_packet;
	// ex_cp output, the broadcast
	cdb_packet_t cdb_packet;
	logic        stall;
	logic        halt_fetch;

	////////////////////
	// fetch
	////////////////////
	if_stage #(.reset_pc(reset_pc)) if_stage_inst (
		.clock        (clock),
		.reset        (reset),
		.stall        (stall),
		.halt_fetch   (halt_fetch),
		.mem2proc_data(mem2proc_data),
		.proc2mem_addr(proc2mem_addr),
		.if_packet    (if_packet)
	);

	// holds while dispatch stalls
	stage_reg #(.payload_t(if_packet_t)) if_id_reg (
		.clock (clock),
		.reset (reset),
		.hold  (stall),
		.bubble(halt_fetch),
		.d     (if_packet),
		.q     (if_id_packet)
	);

	////////////////////
	// dispatch and issue
	////////////////////
	dp_is_stage dp_is_stage_inst (
		.clock       (clock),
		.reset       (reset),
		.if_id_packet(if_id_packet),
		.cdb_packet  (cdb_packet),
		.is_packet   (is_packet),
		.stall       (stall),
		.halt_fetch  (halt_fetch)
	);

	// bubble behind a stall or a halt
	stage_reg #(.payload_t(is_packet_t)) is_ex_reg (
		.clock (clock),
		.reset (reset),
		.hold  (1'b0),
		.bubble(stall || halt_fetch),
		.d     (is_packet),
		.q     (is_ex_packet)
	);

	////////////////////
	// execute and broadcast
	////////////////////
	ex_stage ex_stage_inst (
		.is_ex_packet(is_ex_packet),
		.cdb_result  (ex_packet)
	);

	// never stalled
	stage_reg #(.payload_t(cdb_packet_t)) ex_cp_reg (
		.clock (clock),
		.reset (reset),
		.hold  (1'b0),
		.bubble(1'b0),
		.d     (ex_packet),
		.q     (cdb_packet)
	);

	////////////////////
	// retire
	////////////////////
	rt_stage rt_stage_inst (
		.clock         (clock),
		.reset         (reset),
		.cdb_packet    (cdb_packet),
		.commit_valid  (commit_valid),
		.commit_npc    (commit_npc),
		.commit_wr_en  (commit_wr_en),
		.commit_wr_idx (commit_wr_idx),
		.commit_wr_data(commit_wr_data),
		.error_status  (error_status)
	);

endmodule

// ==== design/rt_stage.sv ====
////////////////////
// retire stage
// registered commit port and sticky error status
////////////////////

module rt_stage
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic            clock,
	input  logic            reset,
	input  cdb_packet_t     cdb_packet,
	output logic            commit_valid,
	output logic [xlen-1:0] commit_npc,
	output logic            commit_wr_en,
	output logic [4:0]      commit_wr_idx,
	output logic [xlen-1:0] commit_wr_data,
	output error_code_t     error_status
);

	logic halted;
	logic retire;

	// any code other than no_error means stopped
	assign halted = (error_status != no_error);
	assign retire = cdb_packet.valid && !halted;

	// control state
	always_ff @(posedge clock) begin
		if (reset) begin
			commit_valid <= 1'b0;
			error_status <= no_error;
		end else begin
			commit_valid <= retire;
			if (retire && cdb_packet.illegal) begin
				error_status <= illegal_inst;
			end else if (retire && cdb_packet.halt) begin
				error_status <= halted_on_wfi;
			end
		end
	end

	// commit payload, only meaningful with commit_valid
	always_ff @(posedge clock) begin
		if (retire) begin
			commit_npc     <= cdb_packet.npc;
			commit_wr_en   <= cdb_packet.wr_en;
			commit_wr_idx  <= cdb_packet.dest_idx;
			commit_wr_data <= cdb_packet.result;
		end
	end

endmodule

// ==== design/stage_reg.sv ====
////////////////////
// pipeline register
// stall hold and bubble insertion for any packet type
////////////////////

module stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     hold,
	input  logic     bubble,
	input  payload_t d,
	output payload_t q
);

	// an all-zero payload has valid low
	// bubble wins over hold, so a halt drains a held slot
	always_ff @(posedge clock) begin
		if (reset || bubble) begin
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

// ==== tb.f ====
design/isa_pkg.sv
design/pipe_pkg.sv
design/if_stage.sv
design/stage_reg.sv
design/dp_is_stage.sv
design/ex_stage.sv
design/rt_stage.sv
design/pipeline.sv
tb/pipeline_tb.sv

// ==== tb/pipeline_tb.sv ====
////////////////////
// pipeline testbench
// random and directed programs in a combinational
// instruction memory, checked commit by commit
// against an in-order model of the instruction set
////////////////////

module pipeline_tb
	import isa_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [xlen-1:0] reset_pc = 32'h0000_0080;
	localparam int mem_words      = 256;
	localparam int prog_max       = 200;
	localparam int commit_timeout = 2000;
	localparam int quiet_cycles   = 50;

	// instruction kinds with the alu kinds first for range tests
	typedef enum int {
		k_add, k_sub, k_and, k_or, k_xor, k_slt,
		k_addi, k_andi, k_ori, k_xori, k_lui,
		k_wfi, k_bad
	} kind_t;

	// one expected retirement
	typedef struct packed {
		logic [xlen-1:0] npc;
		logic            wr_en;
		logic [4:0]      idx;
		logic [xlen-1:0] data;
	} commit_t;

	logic            clock;
	logic            reset;
	inst_t           mem2proc_data;
	logic [xlen-1:0] proc2mem_addr;
	logic            commit_valid;
	logic [xlen-1:0] commit_npc;
	logic            commit_wr_en;
	logic [4:0]      commit_wr_idx;
	logic [xlen-1:0] commit_wr_data;
	error_code_t     error_status;

	logic [31:0] imem [0:mem_words-1];
	// program as fields that get encoded into imem at load
	kind_t       prog_kind [0:prog_max-1];
	logic [4:0]  prog_rd [0:prog_max-1];
	logic [4:0]  prog_rs1 [0:prog_max-1];
	logic [4:0]  prog_rs2 [0:prog_max-1];
	logic [19:0] prog_imm [0:prog_max-1];
	int          prog_len;
	commit_t     exp_q [$];

	integer seed;
	int     error_count;
	int     test_count;
	int     failed_count;

	pipeline #(.reset_pc(reset_pc)) pipeline_inst (
		.clock         (clock),
		.reset         (reset),
		.mem2proc_data (mem2proc_data),
		.proc2mem_addr (proc2mem_addr),
		.commit_valid  (commit_valid),
		.commit_npc    (commit_npc),
		.commit_wr_en  (commit_wr_en),
		.commit_wr_idx (commit_wr_idx),
		.commit_wr_data(commit_wr_data),
		.error_status  (error_status)
	);

	// same-cycle instruction memory
	assign mem2proc_data = imem[proc2mem_addr[9:2]];

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////
	// program building
	////////////////////
	task automatic append_inst(input kind_t kind, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic [19:0] imm);
		prog_kind[prog_len] = kind;
		prog_rd[prog_len]   = rd;
		prog_rs1[prog_len]  = rs1;
		prog_rs2[prog_len]  = rs2;
		prog_imm[prog_len]  = imm;
		prog_len++;
	endtask

	// x0..x7 only so hazards and x0 writes come up often
	function automatic logic [4:0] rand_reg();
		return 5'($unsigned($random(seed)) % 8);
	endfunction

	task automatic append_random(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2, input int kinds);
		kind_t kind;
		kind = kind_t'($unsigned($random(seed)) % kinds);
		append_inst(kind, rd, rs1, rs2, 20'($random(seed)));
	endtask

	function automatic logic [31:0] encode_inst(input int i);
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm12;
		rd    = prog_rd[i];
		rs1   = prog_rs1[i];
		rs2   = prog_rs2[i];
		imm12 = prog_imm[i][11:0];
		case (prog_kind[i])
			k_add:   return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
			k_sub:   return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
			k_and:   return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
			k_or:    return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
			k_xor:   return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
			k_slt:   return {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
			k_addi:  return {imm12, rs1, 3'b000, rd, 7'b0010011};
			k_andi:  return {imm12, rs1, 3'b111, rd, 7'b0010011};
			k_ori:   return {imm12, rs1, 3'b110, rd, 7'b0010011};
			k_xori:  return {imm12, rs1, 3'b100, rd, 7'b0010011};
			k_lui:   return {prog_imm[i], rd, 7'b0110111};
			k_wfi:   return 32'h1050_0073;
			// load word into x0 which this core does not implement
			default: return 32'h0000_2003;
		endcase
	endfunction

	// fill words end in 2'b00 which is never a legal opcode
	task automatic load_memory();
		for (int w = 0; w < mem_words; w++) begin
			imem[w] = 32'hffff_0000 | 32'(w << 2);
		end
		for (int i = 0; i < prog_len; i++) begin
			imem[(reset_pc >> 2) + i] = encode_inst(i);
		end
	endtask

	////////////////////
	// reference model
	////////////////////
	task automatic compute_expected();
		logic [31:0] regs [0:31];
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		commit_t     c;
		exp_q.delete();
		for (int r = 0; r < 32; r++) begin
			regs[r] = '0;
		end
		for (int i = 0; i < prog_len; i++) begin
			a = regs[prog_rs1[i]];
			b = regs[prog_rs2[i]];
			if (prog_kind[i] >= k_addi && prog_kind[i] <= k_xori) begin
				b = {{20{prog_imm[i][11]}}, prog_imm[i][11:0]};
			end
			case (prog_kind[i])
				k_add, k_addi: res = a + b;
				k_sub:         res = a - b;
				k_and, k_andi: res = a & b;
				k_or, k_ori:   res = a | b;
				k_xor, k_xori: res = a ^ b;
				k_slt:         res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				k_lui:         res = {prog_imm[i], 12'b0};
				default:       res = '0;
			endcase
			c.npc   = reset_pc + 32'(4 * (i + 1));
			c.wr_en = (prog_kind[i] <= k_lui) && (prog_rd[i] != 5'd0);
			c.idx   = prog_rd[i];
			c.data  = res;
			exp_q.push_back(c);
			// wfi and illegal end the program
			if (prog_kind[i] >= k_wfi) begin
				break;
			end
			if (c.wr_en) begin
				regs[prog_rd[i]] = res;
			end
		end
	endtask

	////////////////////
	// checks and run control
	////////////////////
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic reset_and_load();
		@(posedge clock);
		#1 reset = 1'b1;
		load_memory();
		repeat (4) @(posedge clock);
		#1 reset = 1'b0;
	endtask

	task automatic watch_commits(input error_code_t exp_status);
		commit_t exp;
		int      cycles;
		cycles = 0;
		while (exp_q.size() > 0 && cycles < commit_timeout) begin
			@(negedge clock);
			cycles++;
			if (commit_valid) begin
				exp = exp_q.pop_front();
				check_value("commit_npc", commit_npc, exp.npc);
				check_value("commit_wr_en", 32'(commit_wr_en), 32'(exp.wr_en));
				if (exp.wr_en) begin
					check_value("commit_wr_idx", 32'(commit_wr_idx), 32'(exp.idx));
					check_value("commit_wr_data", commit_wr_data, exp.data);
				end
				if (exp_q.size() > 0) begin
					check_value("error_status", 32'(error_status), 32'(no_error));
				end
			end
		end
		if (exp_q.size() > 0) begin
			$display("timeout: %0d expected commits did not appear within %0d cycles",
				exp_q.size(), commit_timeout);
			error_count++;
		end else begin
			check_value("error_status", 32'(error_status), 32'(exp_status));
			// halted pipeline stays quiet
			for (int q = 0; q < quiet_cycles; q++) begin
				@(negedge clock);
				if (commit_valid) begin
					$display("a commit appeared %0d cycles after the halting instruction", q + 1);
					error_count++;
				end
			end
		end
	endtask

	task automatic run_test(input string name, input error_code_t exp_status);
		int errors_before;
		errors_before = error_count;
		test_count++;
		compute_expected();
		reset_and_load();
		// first fetch right after reset
		check_value("proc2mem_addr", proc2mem_addr, reset_pc);
		watch_commits(exp_status);
		if (error_count == errors_before) begin
			$display("test %s ok", name);
		end else begin
			failed_count++;
			$display("test %s FAILED", name);
		end
	endtask

	////////////////////
	// tests
	////////////////////
	task automatic test_first_fetch();
		prog_len = 0;
		append_inst(k_addi, 5'd1, 5'd0, 5'd0, 20'h00123);
		append_inst(k_add, 5'd2, 5'd1, 5'd1, 20'h0);
		append_inst(k_wfi, 5'd0, 5'd0, 5'd0, 20'h0);
		run_test("first_fetch", halted_on_wfi);
	endtask

	task automatic test_random_program();
		prog_len = 0;
		repeat (80) begin
			append_random(rand_reg(), rand_reg(), rand_reg(), 11);
		end
		append_inst(k_wfi, 5'd0, 5'd0, 5'd0, 20'h0);
		run_test("random_program", halted_on_wfi);
	endtask

	task automatic test_dependent_chain();
		logic [4:0] prev;
		logic [4:0] older;
		logic [4:0] rd;
		prog_len = 0;
		append_inst(k_addi, 5'd1, 5'd0, 5'd0, 20'($random(seed)));
		append_inst(k_lui, 5'd2, 5'd0, 5'd0, 20'($random(seed)));
		older = 5'd1;
		prev  = 5'd2;
		for (int i = 0; i < 16; i++) begin
			rd = 5'(3 + (i % 6));
			// reads the result just before it with lui left out
			append_random(rd, prev, older, 10);
			older = prev;
			prev  = rd;
		end
		append_inst(k_wfi, 5'd0, 5'd0, 5'd0, 20'h0);
		run_test("dependent_chain", halted_on_wfi);
	endtask

	task automatic test_x0_writes();
		prog_len = 0;
		append_inst(k_addi, 5'd3, 5'd0, 5'd0, 20'd77);
		append_inst(k_addi, 5'd0, 5'd3, 5'd0, 20'd5);
		append_inst(k_add, 5'd0, 5'd3, 5'd3, 20'h0);
		append_inst(k_lui, 5'd0, 5'd0, 5'd0, 20'habcde);
		// reads of x0 after the writes
		append_inst(k_add, 5'd4, 5'd0, 5'd3, 20'h0);
		append_inst(k_ori, 5'd5, 5'd0, 5'd0, 20'h000f0);
		append_inst(k_sub, 5'd6, 5'd0, 5'd3, 20'h0);
		append_inst(k_slt, 5'd7, 5'd0, 5'd3, 20'h0);
		append_inst(k_wfi, 5'd0, 5'd0, 5'd0, 20'h0);
		run_test("x0_writes", halted_on_wfi);
	endtask

	task automatic test_halt_on_wfi();
		prog_len = 0;
		repeat (6) begin
			append_random(rand_reg(), rand_reg(), rand_reg(), 11);
		end
		append_inst(k_wfi, 5'd0, 5'd0, 5'd0, 20'h0);
		// never retire
		repeat (6) begin
			append_random(rand_reg(), rand_reg(), rand_reg(), 11);
		end
		run_test("halt_on_wfi", halted_on_wfi);
	endtask

	task automatic test_illegal_inst();
		prog_len = 0;
		append_inst(k_addi, 5'd1, 5'd0, 5'd0, 20'd9);
		append_inst(k_xori, 5'd2, 5'd1, 5'd0, 20'hfffff);
		append_inst(k_bad, 5'd0, 5'd0, 5'd0, 20'h0);
		append_inst(k_addi, 5'd3, 5'd0, 5'd0, 20'd1);
		append_inst(k_add, 5'd4, 5'd1, 5'd1, 20'h0);
		append_inst(k_wfi, 5'd0, 5'd0, 5'd0, 20'h0);
		run_test("illegal_inst", illegal_inst);
	endtask

	initial begin
		reset        = 1'b1;
		seed         = 66;
		error_count  = 0;
		test_count   = 0;
		failed_count = 0;
		prog_len     = 0;
		load_memory();
		test_first_fetch();
		test_random_program();
		test_dependent_chain();
		test_x0_writes();
		test_halt_on_wfi();
		test_illegal_inst();
		$display("tests run %0d, tests failed %0d, errors %0d",
			test_count, failed_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
